// ==== hw/rv_config.svh ====
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data path and instruction word
`define RV_XLEN 32

// pc without the two always-zero low bits
`define RV_PC_W 30

// register file address
`define RV_REG_ADDR_W 5

// csr index, bits 31..20 of a system word
`define RV_CSR_IDX_W 12

// addi x0, x0, 0
`define RV_NOP_INSTR 32'h0000_0013

// alu control, bit 4 marks the arithmetic shift
`define RV_ALU_CTRL_W 5

`endif

// ==== hw/rv_pkg.sv ====
`include "rv_config.svh"

package rv_pkg;

    // major opcode groups, instr[6:2] with instr[1:0] == 2'b11
    typedef enum logic [3:0]
    {
        OPG_LOAD      = 4'd0,
        OPG_MISC_MEM  = 4'd1,
        OPG_ARITH_IMM = 4'd2,
        OPG_AUIPC     = 4'd3,
        OPG_STORE     = 4'd4,
        OPG_ARITH_REG = 4'd5,
        OPG_LUI       = 4'd6,
        OPG_BRANCH    = 4'd7,
        OPG_JALR      = 4'd8,
        OPG_JAL       = 4'd9,
        OPG_SYSTEM    = 4'd10,
        OPG_NONE      = 4'd15
    } rv_opgroup_e;

    // shr_a is shr_l with the top bit set
    typedef enum logic [`RV_ALU_CTRL_W-1:0]
    {
        ALU_ADD      = 5'h00,
        ALU_SUB      = 5'h01,
        ALU_XOR      = 5'h02,
        ALU_OR       = 5'h03,
        ALU_AND      = 5'h04,
        ALU_SHL      = 5'h05,
        ALU_SHR_L    = 5'h06,
        ALU_CMP_EQ   = 5'h08,
        ALU_CMP_NEQ  = 5'h09,
        ALU_CMP_LTS  = 5'h0a,
        ALU_CMP_LTU  = 5'h0b,
        ALU_CMP_NLTS = 5'h0c,
        ALU_CMP_NLTU = 5'h0d,
        ALU_SHR_A    = 5'h16
    } rv_alu_ctrl_e;

    // writeback source
    typedef enum logic [1:0]
    {
        RES_ALU    = 2'd0,
        RES_MEMORY = 2'd1,
        RES_PC_P4  = 2'd2
    } rv_res_src_e;

endpackage

// ==== hw/rv_decode_regs.sv ====
`timescale 1ns/1ps

`include "rv_config.svh"

module rv_decode_regs
(
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_stall,
    input  logic                    i_flush,
    input  logic [`RV_XLEN-1:0]     i_instr,
    input  logic [`RV_PC_W-1:0]     i_pc,
    input  logic [`RV_PC_W-1:0]     i_pc_p4,
    output logic [`RV_XLEN-1:0]     o_instr,
    output logic [`RV_PC_W-1:0]     o_pc,
    output logic [`RV_PC_W-1:0]     o_pc_p4
);

    logic w_clear;

    // reset acts as a flush; flush wins over stall
    assign w_clear = !i_rst_n || i_flush;

    always_ff @(posedge i_clk)
    begin
        if (w_clear)
        begin
            o_instr <= `RV_NOP_INSTR;
            o_pc    <= '0;
            o_pc_p4 <= '0;
        end
        else if (!i_stall)
        begin
            o_instr <= i_instr;
            o_pc    <= i_pc;
            o_pc_p4 <= i_pc_p4;
        end
    end

endmodule

// ==== hw/rv_instr_classify.sv ====
`timescale 1ns/1ps

`include "rv_config.svh"

module rv_instr_classify
    import rv_pkg::*;
(
    input  logic [`RV_XLEN-1:0]     i_instr,
    output rv_opgroup_e             o_group,
    output logic                    o_supported
);

    logic [2:0] w_funct3;
    logic [6:0] w_funct7;
    logic       w_funct7_ok;

    assign w_funct3 = i_instr[14:12];
    assign w_funct7 = i_instr[31:25];

    // only the two values the base isa uses
    assign w_funct7_ok = (w_funct7 == 7'b0000000) || (w_funct7 == 7'b0100000);

    always_comb
    begin
        o_group = OPG_NONE;
        // compressed words never reach a group
        if (i_instr[1:0] == 2'b11)
        begin
            case (i_instr[6:2])
                5'b00000: o_group = OPG_LOAD;
                5'b00011: o_group = OPG_MISC_MEM;
                5'b00100: o_group = OPG_ARITH_IMM;
                5'b00101: o_group = OPG_AUIPC;
                5'b01000: o_group = OPG_STORE;
                5'b01100: o_group = OPG_ARITH_REG;
                5'b01101: o_group = OPG_LUI;
                5'b11000: o_group = OPG_BRANCH;
                5'b11001: o_group = OPG_JALR;
                5'b11011: o_group = OPG_JAL;
                5'b11100: o_group = OPG_SYSTEM;
                default:  o_group = OPG_NONE;
            endcase
        end
    end

    always_comb
    begin
        o_supported = 1'b0;
        case (o_group)
            OPG_LOAD:
                o_supported = w_funct3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
            // fence and fence.i
            OPG_MISC_MEM:
                o_supported = (w_funct3 == 3'd0) || (w_funct3 == 3'd1);
            OPG_ARITH_IMM:
            begin
                if ((w_funct3 == 3'd1) || (w_funct3 == 3'd5))
                    o_supported = w_funct7_ok;
                else
                    o_supported = 1'b1;
            end
            OPG_STORE:
                o_supported = w_funct3 inside {3'd0, 3'd1, 3'd2};
            OPG_ARITH_REG:
            begin
                // 0100000 only for sub and sra
                if (w_funct7 == 7'b0000000)
                    o_supported = 1'b1;
                else if (w_funct7 == 7'b0100000)
                    o_supported = (w_funct3 == 3'd0) || (w_funct3 == 3'd5);
                else
                    o_supported = 1'b0;
            end
            OPG_BRANCH:
                o_supported = (w_funct3 != 3'd2) && (w_funct3 != 3'd3);
            OPG_JALR:
                o_supported = (w_funct3 == 3'd0);
            OPG_LUI, OPG_AUIPC, OPG_JAL:
                o_supported = 1'b1;
            // system words trap, as does anything unknown
            default:
                o_supported = 1'b0;
        endcase
    end

endmodule

// ==== hw/rv_imm_gen.sv ====
`timescale 1ns/1ps

`include "rv_config.svh"

module rv_imm_gen
    import rv_pkg::*;
(
    input  logic [`RV_XLEN-1:0]     i_instr,
    input  rv_opgroup_e             i_group,
    input  logic                    i_supported,
    output logic [`RV_XLEN-1:0]     o_imm
);

    logic w_sign;

    assign w_sign = i_instr[31];

    always_comb
    begin
        o_imm = '0;
        if (i_supported)
        begin
            case (i_group)
                // j-type
                OPG_JAL:
                    o_imm = {{12{w_sign}}, i_instr[19:12], i_instr[20],
                             i_instr[30:21], 1'b0};
                // u-type
                OPG_LUI, OPG_AUIPC:
                    o_imm = {i_instr[31:12], 12'b0};
                // i-type, shift amounts ride in the low bits
                OPG_JALR, OPG_LOAD, OPG_ARITH_IMM:
                    o_imm = {{21{w_sign}}, i_instr[30:20]};
                // b-type
                OPG_BRANCH:
                    o_imm = {{20{w_sign}}, i_instr[7], i_instr[30:25],
                             i_instr[11:8], 1'b0};
                // s-type
                OPG_STORE:
                    o_imm = {{21{w_sign}}, i_instr[30:25], i_instr[11:7]};
                default:
                    o_imm = '0;
            endcase
        end
    end

endmodule

// ==== hw/rv_ctrl_gen.sv ====
`timescale 1ns/1ps

`include "rv_config.svh"

module rv_ctrl_gen
    import rv_pkg::*;
(
    input  rv_opgroup_e                 i_group,
    input  logic                        i_supported,
    input  logic [2:0]                  i_funct3,
    input  logic                        i_funct7_b5,
    input  logic [`RV_REG_ADDR_W-1:0]   i_rd,
    input  logic [`RV_REG_ADDR_W-1:0]   i_rs1,
    output logic                        o_rs1_zero_lui,
    output logic                        o_reg_write,
    output logic                        o_mem_read,
    output logic                        o_mem_write,
    output rv_res_src_e                 o_res_src,
    output logic                        o_pc_sel,
    output logic                        o_jump,
    output logic                        o_branch,
    output logic                        o_alu_op1_sel,
    output logic                        o_alu_op2_sel,
    output rv_alu_ctrl_e                o_alu_ctrl,
    output logic                        o_csr_read,
    output logic                        o_csr_write
);

    logic w_sys;
    logic w_rd_nz;
    logic w_rs1_nz;

    // lui always decodes as supported
    assign o_rs1_zero_lui = (i_group == OPG_LUI);

    always_comb
    begin
        o_reg_write   = 1'b0;
        o_mem_read    = 1'b0;
        o_mem_write   = 1'b0;
        o_res_src     = RES_ALU;
        o_pc_sel      = 1'b0;
        o_jump        = 1'b0;
        o_branch      = 1'b0;
        o_alu_op1_sel = 1'b0;
        o_alu_op2_sel = 1'b0;
        if (i_supported)
        begin
            o_reg_write = i_group inside {OPG_LOAD, OPG_ARITH_IMM, OPG_AUIPC,
                                          OPG_ARITH_REG, OPG_LUI, OPG_JALR, OPG_JAL};
            o_mem_read  = (i_group == OPG_LOAD);
            o_mem_write = (i_group == OPG_STORE);
            o_branch    = (i_group == OPG_BRANCH);
            o_jump      = (i_group == OPG_JAL) || (i_group == OPG_JALR);
            // jalr target comes from the alu
            o_pc_sel    = (i_group == OPG_JALR);
            o_alu_op1_sel = (i_group == OPG_AUIPC) || (i_group == OPG_JAL);
            o_alu_op2_sel = i_group inside {OPG_AUIPC, OPG_JAL, OPG_JALR, OPG_LUI,
                                            OPG_ARITH_IMM, OPG_LOAD, OPG_STORE};
            if (i_group == OPG_LOAD)
                o_res_src = RES_MEMORY;
            else if (o_jump)
                o_res_src = RES_PC_P4;
        end
    end

    always_comb
    begin
        o_alu_ctrl = ALU_ADD;
        if (i_supported)
        begin
            if ((i_group == OPG_ARITH_REG) || (i_group == OPG_ARITH_IMM))
            begin
                case (i_funct3)
                    // no subtract-immediate
                    3'd0: o_alu_ctrl = (i_funct7_b5 && (i_group == OPG_ARITH_REG)) ?
                                       ALU_SUB : ALU_ADD;
                    3'd1: o_alu_ctrl = ALU_SHL;
                    3'd2: o_alu_ctrl = ALU_CMP_LTS;
                    3'd3: o_alu_ctrl = ALU_CMP_LTU;
                    3'd4: o_alu_ctrl = ALU_XOR;
                    3'd5: o_alu_ctrl = i_funct7_b5 ? ALU_SHR_A : ALU_SHR_L;
                    3'd6: o_alu_ctrl = ALU_OR;
                    default: o_alu_ctrl = ALU_AND;
                endcase
            end
            else if (i_group == OPG_BRANCH)
            begin
                case (i_funct3)
                    3'd0: o_alu_ctrl = ALU_CMP_EQ;
                    3'd1: o_alu_ctrl = ALU_CMP_NEQ;
                    3'd4: o_alu_ctrl = ALU_CMP_LTS;
                    3'd5: o_alu_ctrl = ALU_CMP_NLTS;
                    3'd6: o_alu_ctrl = ALU_CMP_LTU;
                    default: o_alu_ctrl = ALU_CMP_NLTU;
                endcase
            end
        end
    end

    // csr enables feed the trap path, so no supported gate here
    assign w_sys    = (i_group == OPG_SYSTEM);
    assign w_rd_nz  = |i_rd;
    assign w_rs1_nz = |i_rs1;

    always_comb
    begin
        o_csr_read  = 1'b0;
        o_csr_write = 1'b0;
        if (w_sys)
        begin
            case (i_funct3)
                // csrrw, csrrwi
                3'd1, 3'd5:
                begin
                    o_csr_read  = w_rd_nz;
                    o_csr_write = 1'b1;
                end
                // set and clear forms
                3'd2, 3'd3, 3'd6, 3'd7:
                begin
                    o_csr_read  = 1'b1;
                    o_csr_write = w_rs1_nz;
                end
                default:
                begin
                    o_csr_read  = 1'b0;
                    o_csr_write = 1'b0;
                end
            endcase
        end
    end

endmodule

// ==== hw/rv_decode_top.sv ====
`timescale 1ns/1ps

`include "rv_config.svh"

module rv_decode_top
    import rv_pkg::*;
(
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_stall,
    input  logic                        i_flush,
    input  logic [`RV_XLEN-1:0]         i_instr,
    input  logic [`RV_PC_W-1:0]         i_pc,
    input  logic [`RV_PC_W-1:0]         i_pc_p4,
    output logic [`RV_REG_ADDR_W-1:0]   o_rs1,
    output logic [`RV_REG_ADDR_W-1:0]   o_rs2,
    output logic [`RV_REG_ADDR_W-1:0]   o_rd,
    output logic [`RV_PC_W-1:0]         o_pc,
    output logic [`RV_PC_W-1:0]         o_pc_p4,
    output logic [`RV_XLEN-1:0]         o_imm,
    output logic                        o_reg_write,
    output logic                        o_mem_read,
    output logic                        o_mem_write,
    output rv_res_src_e                 o_res_src,
    output logic                        o_pc_sel,
    output logic                        o_jump,
    output logic                        o_branch,
    output logic                        o_alu_op1_sel,
    output logic                        o_alu_op2_sel,
    output logic [2:0]                  o_funct3,
    output rv_alu_ctrl_e                o_alu_ctrl,
    output logic                        o_inv_instr,
    output logic [`RV_CSR_IDX_W-1:0]    o_csr_idx,
    output logic                        o_csr_read,
    output logic                        o_csr_write
);

    logic [`RV_XLEN-1:0]    r_instr;
    rv_opgroup_e            w_group;
    logic                   w_supported;
    logic                   w_rs1_zero_lui;

    rv_decode_regs u_regs
    (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_stall (i_stall),
        .i_flush (i_flush),
        .i_instr (i_instr),
        .i_pc    (i_pc),
        .i_pc_p4 (i_pc_p4),
        .o_instr (r_instr),
        .o_pc    (o_pc),
        .o_pc_p4 (o_pc_p4)
    );

    rv_instr_classify u_classify
    (
        .i_instr     (r_instr),
        .o_group     (w_group),
        .o_supported (w_supported)
    );

    rv_imm_gen u_imm
    (
        .i_instr     (r_instr),
        .i_group     (w_group),
        .i_supported (w_supported),
        .o_imm       (o_imm)
    );

    rv_ctrl_gen u_ctrl
    (
        .i_group        (w_group),
        .i_supported    (w_supported),
        .i_funct3       (r_instr[14:12]),
        .i_funct7_b5    (r_instr[30]),
        .i_rd           (r_instr[11:7]),
        .i_rs1          (r_instr[19:15]),
        .o_rs1_zero_lui (w_rs1_zero_lui),
        .o_reg_write    (o_reg_write),
        .o_mem_read     (o_mem_read),
        .o_mem_write    (o_mem_write),
        .o_res_src      (o_res_src),
        .o_pc_sel       (o_pc_sel),
        .o_jump         (o_jump),
        .o_branch       (o_branch),
        .o_alu_op1_sel  (o_alu_op1_sel),
        .o_alu_op2_sel  (o_alu_op2_sel),
        .o_alu_ctrl     (o_alu_ctrl),
        .o_csr_read     (o_csr_read),
        .o_csr_write    (o_csr_write)
    );

    // lui adds its immediate to x0
    assign o_rs1       = w_rs1_zero_lui ? '0 : r_instr[19:15];
    assign o_rs2       = r_instr[24:20];
    assign o_rd        = r_instr[11:7];
    assign o_funct3    = r_instr[14:12];
    assign o_csr_idx   = r_instr[31:20];
    assign o_inv_instr = !w_supported;

endmodule

// ==== tests/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen
(
    output logic o_clk
);

    // 8 ns period
    initial
    begin
        o_clk = 1'b0;
        forever
        begin
            #4 o_clk = ~o_clk;
        end
    end

endmodule

// ==== tests/tb_rv_decode.sv ====
`timescale 1ns/1ps

`include "rv_config.svh"

module tb_rv_decode
    import rv_pkg::*;
();

    localparam int WAIT_LIMIT = 16;

    logic                       clk;
    logic                       rst_n;
    logic                       stall;
    logic                       flush;
    logic [`RV_XLEN-1:0]        instr;
    logic [`RV_PC_W-1:0]        pc;
    logic [`RV_PC_W-1:0]        pc_p4;
    logic [`RV_REG_ADDR_W-1:0]  dec_rs1;
    logic [`RV_REG_ADDR_W-1:0]  dec_rs2;
    logic [`RV_REG_ADDR_W-1:0]  dec_rd;
    logic [`RV_PC_W-1:0]        dec_pc;
    logic [`RV_PC_W-1:0]        dec_pc_p4;
    logic [`RV_XLEN-1:0]        dec_imm;
    logic                       dec_reg_write;
    logic                       dec_mem_read;
    logic                       dec_mem_write;
    rv_res_src_e                dec_res_src;
    logic                       dec_pc_sel;
    logic                       dec_jump;
    logic                       dec_branch;
    logic                       dec_op1_sel;
    logic                       dec_op2_sel;
    logic [2:0]                 dec_funct3;
    rv_alu_ctrl_e               dec_alu_ctrl;
    logic                       dec_inv_instr;
    logic [`RV_CSR_IDX_W-1:0]   dec_csr_idx;
    logic                       dec_csr_read;
    logic                       dec_csr_write;

    // model of the stage register
    logic [`RV_XLEN-1:0]        m_instr;
    logic [`RV_PC_W-1:0]        m_pc;
    logic [`RV_PC_W-1:0]        m_pc_p4;

    // expected decode of m_instr
    logic [`RV_XLEN-1:0]        e_imm;
    logic [`RV_REG_ADDR_W-1:0]  e_rs1;
    logic                       e_reg_write;
    logic                       e_mem_read;
    logic                       e_mem_write;
    rv_res_src_e                e_res_src;
    logic                       e_pc_sel;
    logic                       e_jump;
    logic                       e_branch;
    logic                       e_op1_sel;
    logic                       e_op2_sel;
    rv_alu_ctrl_e               e_alu;
    logic                       e_inv;
    logic                       e_csr_read;
    logic                       e_csr_write;

    int                         fall_cnt = 0;
    int                         rng_seed;

    tb_clk_gen u_clk_gen
    (
        .o_clk (clk)
    );

    rv_decode_top u_rv_decode_top
    (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_stall       (stall),
        .i_flush       (flush),
        .i_instr       (instr),
        .i_pc          (pc),
        .i_pc_p4       (pc_p4),
        .o_rs1         (dec_rs1),
        .o_rs2         (dec_rs2),
        .o_rd          (dec_rd),
        .o_pc          (dec_pc),
        .o_pc_p4       (dec_pc_p4),
        .o_imm         (dec_imm),
        .o_reg_write   (dec_reg_write),
        .o_mem_read    (dec_mem_read),
        .o_mem_write   (dec_mem_write),
        .o_res_src     (dec_res_src),
        .o_pc_sel      (dec_pc_sel),
        .o_jump        (dec_jump),
        .o_branch      (dec_branch),
        .o_alu_op1_sel (dec_op1_sel),
        .o_alu_op2_sel (dec_op2_sel),
        .o_funct3      (dec_funct3),
        .o_alu_ctrl    (dec_alu_ctrl),
        .o_inv_instr   (dec_inv_instr),
        .o_csr_idx     (dec_csr_idx),
        .o_csr_read    (dec_csr_read),
        .o_csr_write   (dec_csr_write)
    );

    always @(negedge clk)
    begin
        fall_cnt <= fall_cnt + 1;
    end

    // returns 1 ns after the next falling edge
    task automatic wait_fall();
        int start;
        int guard;
        start = fall_cnt;
        guard = 0;
        while ((fall_cnt == start) && (guard < WAIT_LIMIT))
        begin
            #1;
            guard++;
        end
        if (fall_cnt == start)
        begin
            $display("Timeout: the clock made no falling edge within %0d ns", WAIT_LIMIT);
            $display("Finished with errors");
            $fatal(1, "clock stopped");
        end
    endtask

    function automatic logic [4:0] rand_reg();
        return 5'($urandom);
    endfunction

    // random word with opcode, funct3 and sign bit forced
    function automatic logic [31:0] rand_word(logic [6:0] opc, logic [2:0] f3, logic sign);
        logic [31:0] w;
        w = $urandom;
        w[31] = sign;
        w[14:12] = f3;
        w[6:0] = opc;
        return w;
    endfunction

    function automatic rv_alu_ctrl_e arith_op(logic [2:0] f3, logic b30, logic is_reg);
        case (f3)
            3'd0: return (is_reg && b30) ? ALU_SUB : ALU_ADD;
            3'd1: return ALU_SHL;
            3'd2: return ALU_CMP_LTS;
            3'd3: return ALU_CMP_LTU;
            3'd4: return ALU_XOR;
            3'd5: return b30 ? ALU_SHR_A : ALU_SHR_L;
            3'd6: return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // beq bne blt bge bltu bgeu
    function automatic rv_alu_ctrl_e branch_op(logic [2:0] f3);
        case (f3)
            3'd0: return ALU_CMP_EQ;
            3'd1: return ALU_CMP_NEQ;
            3'd4: return ALU_CMP_LTS;
            3'd5: return ALU_CMP_NLTS;
            3'd6: return ALU_CMP_LTU;
            default: return ALU_CMP_NLTU;
        endcase
    endfunction

    task automatic model_decode(logic [31:0] w);
        logic [2:0] f3;
        logic [6:0] f7;
        logic       ok;
        f3 = w[14:12];
        f7 = w[31:25];
        ok = 1'b0;
        e_imm = '0;
        e_rs1 = w[19:15];
        e_reg_write = 1'b0;
        e_mem_read = 1'b0;
        e_mem_write = 1'b0;
        e_res_src = RES_ALU;
        e_pc_sel = 1'b0;
        e_jump = 1'b0;
        e_branch = 1'b0;
        e_op1_sel = 1'b0;
        e_op2_sel = 1'b0;
        e_alu = ALU_ADD;
        e_csr_read = 1'b0;
        e_csr_write = 1'b0;
        case (w[6:0])
            7'h03:
            begin
                ok = f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
                e_imm = {{20{w[31]}}, w[31:20]};
                e_reg_write = 1'b1;
                e_mem_read = 1'b1;
                e_res_src = RES_MEMORY;
                e_op2_sel = 1'b1;
            end
            7'h0f: ok = (f3 <= 3'd1);
            7'h13:
            begin
                ok = ((f3 == 3'd1) || (f3 == 3'd5)) ? ((f7 == 7'h00) || (f7 == 7'h20)) : 1'b1;
                e_imm = {{20{w[31]}}, w[31:20]};
                e_reg_write = 1'b1;
                e_op2_sel = 1'b1;
                e_alu = arith_op(f3, w[30], 1'b0);
            end
            7'h17:
            begin
                ok = 1'b1;
                e_imm = {w[31:12], 12'h000};
                e_reg_write = 1'b1;
                e_op1_sel = 1'b1;
                e_op2_sel = 1'b1;
            end
            7'h23:
            begin
                ok = (f3 <= 3'd2);
                e_imm = {{20{w[31]}}, w[31:25], w[11:7]};
                e_mem_write = 1'b1;
                e_op2_sel = 1'b1;
            end
            7'h33:
            begin
                ok = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
                e_reg_write = 1'b1;
                e_alu = arith_op(f3, w[30], 1'b1);
            end
            7'h37:
            begin
                ok = 1'b1;
                e_imm = {w[31:12], 12'h000};
                e_rs1 = '0;
                e_reg_write = 1'b1;
                e_op2_sel = 1'b1;
            end
            7'h63:
            begin
                ok = (f3 != 3'd2) && (f3 != 3'd3);
                e_imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                e_branch = 1'b1;
                e_alu = branch_op(f3);
            end
            7'h67:
            begin
                ok = (f3 == 3'd0);
                e_imm = {{20{w[31]}}, w[31:20]};
                e_reg_write = 1'b1;
                e_jump = 1'b1;
                e_pc_sel = 1'b1;
                e_res_src = RES_PC_P4;
                e_op2_sel = 1'b1;
            end
            7'h6f:
            begin
                ok = 1'b1;
                e_imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                e_reg_write = 1'b1;
                e_jump = 1'b1;
                e_res_src = RES_PC_P4;
                e_op1_sel = 1'b1;
                e_op2_sel = 1'b1;
            end
            // system words trap but csr enables still decode
            7'h73:
            begin
                if ((f3 == 3'd1) || (f3 == 3'd5))
                begin
                    e_csr_read = |w[11:7];
                    e_csr_write = 1'b1;
                end
                else if ((f3 != 3'd0) && (f3 != 3'd4))
                begin
                    e_csr_read = 1'b1;
                    e_csr_write = |w[19:15];
                end
            end
            default: ok = 1'b0;
        endcase
        if (!ok)
        begin
            e_imm = '0;
            e_reg_write = 1'b0;
            e_mem_read = 1'b0;
            e_mem_write = 1'b0;
            e_res_src = RES_ALU;
            e_pc_sel = 1'b0;
            e_jump = 1'b0;
            e_branch = 1'b0;
            e_op1_sel = 1'b0;
            e_op2_sel = 1'b0;
            e_alu = ALU_ADD;
        end
        e_inv = !ok;
    endtask

    task automatic check_field(string test, string field, logic [31:0] exp_v,
                               logic [31:0] act_v);
        assert (act_v === exp_v)
        else
        begin
            $display("Mismatch in %s, %s: expected %h, actual %h", test, field, exp_v, act_v);
            $display("Finished with errors");
            $fatal(1, "decode output differs from the model");
        end
    endtask

    task automatic check_outputs(string test);
        model_decode(m_instr);
        check_field(test, "rs1", 32'(e_rs1), 32'(dec_rs1));
        check_field(test, "rs2", 32'(m_instr[24:20]), 32'(dec_rs2));
        check_field(test, "rd", 32'(m_instr[11:7]), 32'(dec_rd));
        check_field(test, "funct3", 32'(m_instr[14:12]), 32'(dec_funct3));
        check_field(test, "csr_idx", 32'(m_instr[31:20]), 32'(dec_csr_idx));
        check_field(test, "pc", 32'(m_pc), 32'(dec_pc));
        check_field(test, "pc_p4", 32'(m_pc_p4), 32'(dec_pc_p4));
        check_field(test, "imm", e_imm, dec_imm);
        check_field(test, "reg_write", 32'(e_reg_write), 32'(dec_reg_write));
        check_field(test, "mem_read", 32'(e_mem_read), 32'(dec_mem_read));
        check_field(test, "mem_write", 32'(e_mem_write), 32'(dec_mem_write));
        check_field(test, "res_src", 32'(e_res_src), 32'(dec_res_src));
        check_field(test, "pc_sel", 32'(e_pc_sel), 32'(dec_pc_sel));
        check_field(test, "jump", 32'(e_jump), 32'(dec_jump));
        check_field(test, "branch", 32'(e_branch), 32'(dec_branch));
        check_field(test, "alu_op1_sel", 32'(e_op1_sel), 32'(dec_op1_sel));
        check_field(test, "alu_op2_sel", 32'(e_op2_sel), 32'(dec_op2_sel));
        check_field(test, "alu_ctrl", 32'(e_alu), 32'(dec_alu_ctrl));
        check_field(test, "inv_instr", 32'(e_inv), 32'(dec_inv_instr));
        check_field(test, "csr_read", 32'(e_csr_read), 32'(dec_csr_read));
        check_field(test, "csr_write", 32'(e_csr_write), 32'(dec_csr_write));
    endtask

    // one cycle with fresh random program counters
    task automatic drive_cycle(string test, logic [31:0] word, logic hold, logic clear);
        logic [`RV_PC_W-1:0] new_pc;
        new_pc = `RV_PC_W'($urandom);
        instr = word;
        pc = new_pc;
        pc_p4 = new_pc + 1'b1;
        stall = hold;
        flush = clear;
        if (clear)
        begin
            m_instr = `RV_NOP_INSTR;
            m_pc = '0;
            m_pc_p4 = '0;
        end
        else if (!hold)
        begin
            m_instr = word;
            m_pc = new_pc;
            m_pc_p4 = new_pc + 1'b1;
        end
        wait_fall();
        check_outputs(test);
    endtask

    task automatic test_arith();
        logic [31:0] w;
        for (int f3 = 0; f3 < 8; f3++)
        begin
            for (int alt = 0; alt < 2; alt++)
            begin
                w = rand_word(7'h33, 3'(f3), 1'b0);
                w[31:25] = (alt != 0) ? 7'h20 : 7'h00;
                drive_cycle("arith_reg", w, 1'b0, 1'b0);
                w = rand_word(7'h13, 3'(f3), 1'(alt));
                // shift amounts leave funct7 in the upper immediate
                if ((f3 == 1) || (f3 == 5))
                    w[31:25] = (alt != 0) ? 7'h20 : 7'h00;
                drive_cycle("arith_imm", w, 1'b0, 1'b0);
            end
        end
    endtask

    task automatic test_imm_ctrl();
        logic       s;
        logic [2:0] ld_f3;
        logic [2:0] br_f3;
        for (int i = 0; i < 8; i++)
        begin
            s = 1'(i);
            ld_f3 = ((i % 5) < 3) ? 3'(i % 5) : 3'((i % 5) + 1);
            br_f3 = ((i % 6) < 2) ? 3'(i % 6) : 3'((i % 6) + 2);
            drive_cycle("lui", rand_word(7'h37, 3'($urandom), s), 1'b0, 1'b0);
            drive_cycle("auipc", rand_word(7'h17, 3'($urandom), s), 1'b0, 1'b0);
            drive_cycle("jal", rand_word(7'h6f, 3'($urandom), s), 1'b0, 1'b0);
            drive_cycle("jalr", rand_word(7'h67, 3'd0, s), 1'b0, 1'b0);
            drive_cycle("load", rand_word(7'h03, ld_f3, s), 1'b0, 1'b0);
            drive_cycle("store", rand_word(7'h23, 3'(i % 3), s), 1'b0, 1'b0);
            drive_cycle("branch", rand_word(7'h63, br_f3, s), 1'b0, 1'b0);
        end
        drive_cycle("fence", rand_word(7'h0f, 3'd0, 1'b0), 1'b0, 1'b0);
        drive_cycle("fence_i", rand_word(7'h0f, 3'd1, 1'b0), 1'b0, 1'b0);
    endtask

    task automatic test_illegal();
        logic [31:0] w;
        w = rand_word(7'h33, 3'd0, 1'b0);
        w[31:25] = 7'h01;
        drive_cycle("bad_funct7_reg", w, 1'b0, 1'b0);
        w = rand_word(7'h13, 3'd5, 1'b0);
        w[31:25] = 7'h21;
        drive_cycle("bad_funct7_shift", w, 1'b0, 1'b0);
        drive_cycle("branch_f3_2", rand_word(7'h63, 3'd2, 1'b1), 1'b0, 1'b0);
        drive_cycle("branch_f3_3", rand_word(7'h63, 3'd3, 1'b0), 1'b0, 1'b0);
        drive_cycle("load_f3_3", rand_word(7'h03, 3'd3, 1'b1), 1'b0, 1'b0);
        drive_cycle("store_f3_4", rand_word(7'h23, 3'd4, 1'b1), 1'b0, 1'b0);
        drive_cycle("jalr_f3_1", rand_word(7'h67, 3'd1, 1'b1), 1'b0, 1'b0);
        drive_cycle("fence_f3_2", rand_word(7'h0f, 3'd2, 1'b0), 1'b0, 1'b0);
        w = rand_word(7'h13, 3'd0, 1'b1);
        w[1:0] = 2'b01;
        drive_cycle("compressed", w, 1'b0, 1'b0);
        drive_cycle("unknown_opcode", rand_word(7'h7f, 3'd0, 1'b1), 1'b0, 1'b0);
        drive_cycle("ecall", 32'h0000_0073, 1'b0, 1'b0);
        drive_cycle("ebreak", 32'h0010_0073, 1'b0, 1'b0);
    endtask

    task automatic test_stall_flush();
        drive_cycle("stall_setup", rand_word(7'h03, 3'd2, 1'b1), 1'b0, 1'b0);
        drive_cycle("stall_hold_1", rand_word(7'h6f, 3'd0, 1'b0), 1'b1, 1'b0);
        drive_cycle("stall_hold_2", rand_word(7'h63, 3'd1, 1'b1), 1'b1, 1'b0);
        drive_cycle("flush_in_stall", rand_word(7'h23, 3'd0, 1'b0), 1'b1, 1'b1);
        drive_cycle("stall_after_flush", rand_word(7'h17, 3'd0, 1'b1), 1'b1, 1'b0);
        drive_cycle("stall_release", rand_word(7'h67, 3'd0, 1'b1), 1'b0, 1'b0);
        drive_cycle("flush", rand_word(7'h37, 3'd0, 1'b1), 1'b0, 1'b1);
    endtask

    task automatic test_csr();
        logic [31:0] w;
        for (int f3 = 0; f3 < 8; f3++)
        begin
            for (int k = 0; k < 4; k++)
            begin
                w = rand_word(7'h73, 3'(f3), 1'($urandom));
                w[11:7] = (k % 2 != 0) ? 5'd0 : (rand_reg() | 5'd1);
                w[19:15] = (k / 2 != 0) ? 5'd0 : (rand_reg() | 5'd1);
                drive_cycle("csr", w, 1'b0, 1'b0);
            end
        end
    endtask

    initial
    begin
        rst_n = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        // inputs far from the no-op so only reset can clear the stage
        instr = '1;
        pc = '1;
        pc_p4 = '1;
        m_instr = `RV_NOP_INSTR;
        m_pc = '0;
        m_pc_p4 = '0;
        rng_seed = $urandom(32'h730c629c);
        for (int i = 0; i < 8; i++)
            wait_fall();
        rst_n = 1'b1;
        check_outputs("reset");
        test_arith();
        test_imm_ctrl();
        test_illegal();
        test_stall_flush();
        test_csr();
        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+hw
hw/rv_pkg.sv
hw/rv_decode_regs.sv
hw/rv_instr_classify.sv
hw/rv_imm_gen.sv
hw/rv_ctrl_gen.sv
hw/rv_decode_top.sv
tests/tb_clk_gen.sv
tests/tb_rv_decode.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tb_rv_decode -o tb_rv_decode_sim

# the simulation status is judged from the log below
./obj_dir/tb_rv_decode_sim 2>&1 | tee sim.log

if grep -q "Finished with no errors" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
